//--- verilog.f
verilog/systolic_pkg.sv
verilog/bf16_mul.sv
verilog/bf16_add.sv
verilog/proc_element.sv
verilog/systolic_array.sv
verilog/frame_receiver.sv
verilog/matmul_controller.sv
verilog/neural_chip.sv
sim/neural_chip_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module neural_chip_tb \
    -f verilog.f -o neural_chip_sim \
    && ./obj_dir/neural_chip_sim | tee sim.log \
    && grep -qx "test passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/neural_chip_tb.sv
`timescale 1ns/100ps
`default_nettype none

module neural_chip_tb
    import systolic_pkg::*;
();

    localparam int N_ROWS          = 4;
    localparam int REPLY_LEN       = 1 + 2 * N_WORDS + 1;      // Start byte, result bytes, end byte
    localparam int REPLY_WAIT      = REPLY_LEN * 16 + 50;      // Cycles allowed per reply
    localparam int WATCHDOG_CYCLES = N_ROWS * (26 * 16 + 100);

    typedef struct packed {
        logic [N_WORDS-1:0][WORD_W-1:0] a;      // Column-major A
        logic [N_WORDS-1:0][WORD_W-1:0] b;      // Column-major B
        logic [N_WORDS-1:0][WORD_W-1:0] c;      // Expected C = A x B
        logic                           noise;  // Stray bytes before and after the operands
    } vector_t;

    logic              clk = 1'b0;
    logic              reset;
    logic              rx_valid;
    logic [BYTE_W-1:0] rx_data;
    logic              tx_ack = 1'b1;   // Transmitter free at start
    logic              tx_valid;
    logic [BYTE_W-1:0] tx_data;
    logic              mult_done;

    vector_t           vectors [$];
    logic [BYTE_W-1:0] reply_q [$];     // Every byte the transmitter took
    logic              done_q  [$];     // mult_done_o seen with that byte
    int                rd_ptr;
    integer            seed = 32'h4879;
    int                busy_left = 0;
    logic              tx_valid_prev = 1'b0;
    int                proto_err = 0;   // Handshake faults seen by the transmitter
    int                err_cnt;
    int                check_cnt;
    logic              got_reply;

    always begin
        #20 clk = ~clk;
    end

    neural_chip UUT (
        .clk         (clk),
        .reset       (reset),
        .rx_valid_i  (rx_valid),
        .rx_data_i   (rx_data),
        .tx_ack_i    (tx_ack),
        .tx_valid_o  (tx_valid),
        .tx_data_o   (tx_data),
        .mult_done_o (mult_done)
    );

    // Transmitter model goes busy for a random time after each byte
    always @(negedge clk) begin
        if (tx_valid) begin
            if (!tx_ack) begin
                $display("Byte %h was sent while tx_ack_i was low", tx_data);
                proto_err = proto_err + 1;
            end
            if (tx_valid_prev) begin
                $display("tx_valid_o stayed high for more than one cycle");
                proto_err = proto_err + 1;
            end
            reply_q.push_back(tx_data);
            done_q.push_back(mult_done);
            tx_ack    <= 1'b0;
            busy_left <= {$random(seed)} % 12 + 1;  // 1 to 12 cycles
        end else if (busy_left > 0) begin
            busy_left <= busy_left - 1;
            if (busy_left == 1) tx_ack <= 1'b1;
        end
        tx_valid_prev <= tx_valid;
    end

    // Words given left to right in column-major order
    task automatic add_row(input logic [63:0] a_w, input logic [63:0] b_w,
                           input logic [63:0] c_w, input logic noise);
        vector_t v;
        for (int i = 0; i < N_WORDS; i++) begin
            v.a[i] = a_w[(N_WORDS-1-i)*WORD_W +: WORD_W];
            v.b[i] = b_w[(N_WORDS-1-i)*WORD_W +: WORD_W];
            v.c[i] = c_w[(N_WORDS-1-i)*WORD_W +: WORD_W];
        end
        v.noise = noise;
        vectors.push_back(v);
    endtask

    task automatic load_table();
        add_row(64'h3F80_0000_0000_3F80, 64'h4000_4040_4080_40A0,  // Identity A so C equals B
                64'h4000_4040_4080_40A0, 1'b0);
        add_row(64'h3F80_4040_4000_4080, 64'h40A0_40E0_40C0_4100,  // 19, 43, 22, 50
                64'h4198_422C_41B0_4248, 1'b1);
        add_row(64'h4000_0000_0000_4040, 64'h0000_4080_40A0_0000,  // Zero operands
                64'h0000_4140_4120_0000, 1'b0);
        add_row(64'h3F80_3F80_3F80_3F80, 64'h3F80_4000_4040_4080,  // All ones A
                64'h4040_4040_40E0_40E0, 1'b1);
    endtask

    task automatic send_byte(input logic [BYTE_W-1:0] b);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_data  = b;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic send_frame(input vector_t v);
        if (v.noise) begin
            send_byte(8'h00);  // Ignored while idle
            send_byte(8'h3C);
        end
        send_byte(FRAME_START);
        for (int i = 0; i < N_WORDS; i++) begin
            send_byte(v.a[i][WORD_W-1 -: BYTE_W]);
            send_byte(v.a[i][BYTE_W-1:0]);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            send_byte(v.b[i][WORD_W-1 -: BYTE_W]);
            send_byte(v.b[i][BYTE_W-1:0]);
        end
        if (v.noise) begin
            send_byte(8'hA5);        // Only the end byte closes the frame
            send_byte(FRAME_START);
        end
        send_byte(FRAME_END);
    endtask

    task automatic check_idle(input string phase);
        check_cnt += 2;
        if (tx_valid !== 1'b0) begin
            $display("[FAIL] %s tx_valid_o expected %h got %h", phase, 1'b0, tx_valid);
            err_cnt++;
        end
        if (mult_done !== 1'b0) begin
            $display("[FAIL] %s mult_done_o expected %h got %h", phase, 1'b0, mult_done);
            err_cnt++;
        end
    endtask

    task automatic wait_reply(input int row, output logic got);
        int waited;
        waited = 0;
        while (reply_q.size() < rd_ptr + REPLY_LEN && waited < REPLY_WAIT) begin
            @(posedge clk);
            waited++;
        end
        got = (reply_q.size() >= rd_ptr + REPLY_LEN);
        if (!got) begin
            $display("Row %0d got only %0d reply bytes within %0d cycles",
                     row, reply_q.size() - rd_ptr, REPLY_WAIT);
            err_cnt++;
            rd_ptr = reply_q.size();  // Resync for the next row
        end
    endtask

    task automatic take_byte(output logic [BYTE_W-1:0] b, output logic d);
        b = reply_q[rd_ptr];
        d = done_q[rd_ptr];
        rd_ptr++;
    endtask

    task automatic check_reply(input int row, input vector_t v);
        logic [BYTE_W-1:0] b;
        logic [WORD_W-1:0] word;
        logic              d;
        take_byte(b, d);
        check_cnt += 2;
        if (b !== FRAME_START) begin
            $display("[FAIL] row %0d tx_data_o start expected %h got %h", row, FRAME_START, b);
            err_cnt++;
        end
        if (d !== 1'b1) begin  // Results ready before the first byte
            $display("[FAIL] row %0d mult_done_o expected %h got %h", row, 1'b1, d);
            err_cnt++;
        end
        for (int w = 0; w < N_WORDS; w++) begin
            take_byte(b, d);
            word[WORD_W-1 -: BYTE_W] = b;
            take_byte(b, d);
            word[BYTE_W-1:0] = b;
            check_cnt++;
            if (word !== v.c[w]) begin
                $display("[FAIL] row %0d tx_data_o C%0d%0d expected %h got %h",
                         row, w % ARR_DIM, w / ARR_DIM, v.c[w], word);
                err_cnt++;
            end
        end
        take_byte(b, d);
        check_cnt++;
        if (b !== FRAME_END) begin
            $display("[FAIL] row %0d tx_data_o end expected %h got %h", row, FRAME_END, b);
            err_cnt++;
        end
    endtask

    initial begin
        reset     = 1'b0;
        rx_valid  = 1'b0;
        rx_data   = '0;
        rd_ptr    = 0;
        err_cnt   = 0;
        check_cnt = 0;
        load_table();
        repeat (3) begin
            @(negedge clk);
            check_idle("reset");
        end
        reset = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle("after reset");
        end
        for (int i = 0; i < vectors.size(); i++) begin
            send_frame(vectors[i]);
            wait_reply(i, got_reply);
            if (got_reply) check_reply(i, vectors[i]);
            repeat (2) @(negedge clk);  // Controller back in idle
        end
        repeat (20) @(negedge clk);
        if (reply_q.size() != rd_ptr) begin
            $display("%0d unexpected bytes came after the last reply", reply_q.size() - rd_ptr);
            err_cnt++;
        end
        err_cnt = err_cnt + proto_err;
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/neural_chip.sv
`timescale 1ns/100ps
`default_nettype none

module neural_chip import systolic_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx_valid_i,
    input  logic [BYTE_W-1:0] rx_data_i,
    input  logic              tx_ack_i,
    output logic              tx_valid_o,
    output logic [BYTE_W-1:0] tx_data_o,
    output logic              mult_done_o
);

    operands_t   operands;
    logic        operands_ready;
    logic        busy;
    array_ctrl_t array_ctrl;
    results_t    results;

    frame_receiver u_frame_receiver (
        .clk              (clk),
        .reset            (reset),
        .rx_valid_i       (rx_valid_i),
        .rx_data_i        (rx_data_i),
        .busy_i           (busy),
        .operands_o       (operands),
        .operands_ready_o (operands_ready)
    );

    matmul_controller u_matmul_controller (
        .clk              (clk),
        .reset            (reset),
        .operands_ready_i (operands_ready),
        .done_i           (mult_done_o),
        .results_i        (results),
        .tx_ack_i         (tx_ack_i),
        .ctrl_o           (array_ctrl),
        .busy_o           (busy),
        .tx_valid_o       (tx_valid_o),
        .tx_data_o        (tx_data_o)
    );

    systolic_array u_systolic_array (
        .clk        (clk),
        .reset      (reset),
        .ctrl_i     (array_ctrl),
        .operands_i (operands),
        .results_o  (results),
        .done_o     (mult_done_o)  // Array done goes straight out
    );

endmodule

`default_nettype wire

//--- verilog/matmul_controller.sv
`timescale 1ns/100ps
`default_nettype none

module matmul_controller import systolic_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              operands_ready_i,
    input  logic              done_i,
    input  results_t          results_i,
    input  logic              tx_ack_i,      // Transmitter free
    output array_ctrl_t       ctrl_o,
    output logic              busy_o,
    output logic              tx_valid_o,
    output logic [BYTE_W-1:0] tx_data_o
);

    logic [1:0]             ct_state;
    logic [REPLY_CNT_W-1:0] byte_idx;   // Reply bytes already issued
    logic [REPLY_CNT_W-1:0] res_idx;    // Position within the result bytes
    logic [WIDX_W-1:0]      word_sel;
    logic [BYTE_W-1:0]      next_byte;
    logic                   reply_done;

    assign ctrl_o.load    = (ct_state == CT_LOAD);     // Exactly one cycle
    assign ctrl_o.compute = (ct_state == CT_COMPUTE);

    // Busy already in the ready cycle so no new frame slips in
    assign busy_o = (ct_state != CT_IDLE) || operands_ready_i;

    assign res_idx    = byte_idx - REPLY_CNT_W'(1);
    assign word_sel   = res_idx[WIDX_W:1];
    assign reply_done = (byte_idx == REPLY_CNT_W'(REPLY_BYTES));

    // Start byte, C00..C11 high then low, end byte
    always_comb begin
        if (byte_idx == '0) begin
            next_byte = FRAME_START;
        end else if (byte_idx == REPLY_CNT_W'(REPLY_BYTES - 1)) begin
            next_byte = FRAME_END;
        end else if (!res_idx[0]) begin
            next_byte = results_i[word_sel].raw[WORD_W-1 -: BYTE_W];
        end else begin
            next_byte = results_i[word_sel].raw[BYTE_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ct_state   <= CT_IDLE;
            byte_idx   <= '0;
            tx_valid_o <= 1'b0;
            tx_data_o  <= '0;
        end else begin
            tx_valid_o <= 1'b0;
            case (ct_state)
                CT_IDLE: begin
                    if (operands_ready_i) ct_state <= CT_LOAD;
                end
                CT_LOAD: begin
                    ct_state <= CT_COMPUTE;
                    byte_idx <= '0;
                end
                CT_COMPUTE: begin
                    if (done_i) ct_state <= CT_SEND;  // Results captured in the array
                end
                CT_SEND: begin
                    if (reply_done) begin
                        ct_state <= CT_IDLE;  // End byte is on the bus this cycle
                    end else if (tx_ack_i && !tx_valid_o) begin
                        tx_valid_o <= 1'b1;
                        tx_data_o  <= next_byte;
                        byte_idx   <= byte_idx + REPLY_CNT_W'(1);
                    end
                end
                default: ct_state <= CT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/frame_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module frame_receiver import systolic_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx_valid_i,        // One pulse per byte
    input  logic [BYTE_W-1:0] rx_data_i,
    input  logic              busy_i,            // Core still working on the last frame
    output operands_t         operands_o,
    output logic              operands_ready_o
);

    logic [1:0]          rx_state;
    logic [OP_CNT_W-1:0] byte_cnt;   // Operand byte position in the frame
    logic                take;
    logic [WIDX_W-1:0]   word_sel;
    logic                sel_b;      // Second half of the frame holds B
    logic                hi_byte;    // High byte comes first

    assign take     = rx_valid_i && !busy_i;
    assign word_sel = byte_cnt[WIDX_W:1];
    assign sel_b    = byte_cnt[OP_CNT_W-1];
    assign hi_byte  = !byte_cnt[0];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rx_state         <= RX_IDLE;
            byte_cnt         <= '0;
            operands_ready_o <= 1'b0;
        end else begin
            operands_ready_o <= 1'b0;  // Single cycle pulse
            if (take) begin
                case (rx_state)
                    RX_IDLE: begin
                        if (rx_data_i == FRAME_START) begin  // Anything else is noise
                            rx_state <= RX_DATA;
                            byte_cnt <= '0;
                        end
                    end
                    RX_DATA: begin
                        byte_cnt <= byte_cnt + OP_CNT_W'(1);
                        if (byte_cnt == OP_CNT_W'(OP_BYTES - 1)) begin
                            rx_state <= RX_TAIL;
                        end
                    end
                    RX_TAIL: begin
                        if (rx_data_i == FRAME_END) begin
                            rx_state         <= RX_IDLE;
                            operands_ready_o <= 1'b1;
                        end
                    end
                    default: rx_state <= RX_IDLE;
                endcase
            end
        end
    end

    // Operand bank
    always_ff @(posedge clk) begin
        if (take && rx_state == RX_DATA) begin
            if (!sel_b) begin
                if (hi_byte) operands_o.a[word_sel].raw[WORD_W-1 -: BYTE_W] <= rx_data_i;
                else         operands_o.a[word_sel].raw[BYTE_W-1:0] <= rx_data_i;
            end else begin
                if (hi_byte) operands_o.b[word_sel].raw[WORD_W-1 -: BYTE_W] <= rx_data_i;
                else         operands_o.b[word_sel].raw[BYTE_W-1:0] <= rx_data_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/systolic_array.sv
`timescale 1ns/100ps
`default_nettype none

module systolic_array import systolic_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  array_ctrl_t ctrl_i,
    input  operands_t   operands_i,
    output results_t    results_o,
    output logic        done_o
);

    bf16_u [SKEW_LEN-1:0] act_q [ARR_DIM];  // Skewed activation rows, entry 0 feeds the array
    bf16_u [ARR_DIM-1:0]  dsk_q [SKEW_LEN]; // Bottom partial sums, one stage per step
    bf16_u                west  [ARR_DIM][ARR_DIM];
    bf16_u                north [ARR_DIM][ARR_DIM];
    bf16_u                east  [ARR_DIM][ARR_DIM];
    bf16_u                south [ARR_DIM][ARR_DIM];
    logic  [STEP_W-1:0]   step_cnt;
    logic                 step;
    logic                 last_step;

    // Controller keeps compute up one cycle past done, that cycle is dropped
    assign step      = ctrl_i.compute && !done_o;
    assign last_step = step && (step_cnt == STEP_W'(COMPUTE_STEPS - 1));

    for (genvar r = 0; r < ARR_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARR_DIM; c++) begin : g_col
            if (c == 0) begin : g_west_edge
                assign west[r][c] = act_q[r][0];
            end else begin : g_west_link
                assign west[r][c] = east[r][c-1];
            end
            if (r == 0) begin : g_north_edge
                assign north[r][c] = '0;  // Sums start from zero at the top
            end else begin : g_north_link
                assign north[r][c] = south[r-1][c];
            end

            proc_element u_pe (
                .clk       (clk),
                .reset     (reset),
                .load_i    (ctrl_i.load),
                .compute_i (step),
                .weight_i  (operands_i.b[c*ARR_DIM+r]),  // B(r,c), column-major
                .west_i    (west[r][c]),
                .north_i   (north[r][c]),
                .east_o    (east[r][c]),
                .south_o   (south[r][c])
            );
        end
    end

    // Step counter and done flag
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            step_cnt <= '0;
            done_o   <= 1'b0;
        end else if (ctrl_i.load) begin
            step_cnt <= '0;
            done_o   <= 1'b0;
        end else if (last_step) begin
            step_cnt <= '0;
            done_o   <= 1'b1;  // Held until the next load
        end else if (step) begin
            step_cnt <= step_cnt + STEP_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.load) begin
            for (int r = 0; r < ARR_DIM; r++) begin
                act_q[r] <= '0;
                for (int k = 0; k < ARR_DIM; k++) begin
                    act_q[r][k+r] <= operands_i.a[r*ARR_DIM+k];  // Row r delayed by r
                end
            end
        end else if (step) begin
            for (int r = 0; r < ARR_DIM; r++) begin
                for (int j = 0; j < SKEW_LEN - 1; j++) begin
                    act_q[r][j] <= act_q[r][j+1];
                end
                act_q[r][SKEW_LEN-1] <= '0;
            end
            for (int c = 0; c < ARR_DIM; c++) begin
                dsk_q[0][c] <= south[ARR_DIM-1][c];
            end
            for (int i = 1; i < SKEW_LEN; i++) begin
                dsk_q[i] <= dsk_q[i-1];
            end
        end
        // C(k,c) leaves column c after step k+c+ARR_DIM-1, older ones sit deeper
        if (last_step) begin
            for (int c = 0; c < ARR_DIM; c++) begin
                for (int k = 0; k < ARR_DIM; k++) begin
                    results_o[c*ARR_DIM+k] <= dsk_q[COMPUTE_STEPS-ARR_DIM-2-k-c][c];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/proc_element.sv
`timescale 1ns/100ps
`default_nettype none

module proc_element import systolic_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_i,     // Weight capture
    input  logic  compute_i,  // One array step
    input  bf16_u weight_i,
    input  bf16_u west_i,     // Activation in
    input  bf16_u north_i,    // Partial sum in
    output bf16_u east_o,
    output bf16_u south_o
);

    bf16_u weight_q;  // Stationary for the whole run
    bf16_u prod;
    bf16_u psum;

    bf16_mul u_mul (.a_i(west_i), .b_i(weight_q), .prod_o(prod));
    bf16_add u_add (.a_i(north_i), .b_i(prod), .sum_o(psum));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            weight_q <= '0;
            east_o   <= '0;
            south_o  <= '0;
        end else begin
            if (load_i) begin
                weight_q <= weight_i;
            end
            if (compute_i) begin
                east_o  <= west_i;  // Activation moves on unchanged
                south_o <= psum;    // north + west * weight
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/bf16_add.sv
`timescale 1ns/100ps
`default_nettype none

module bf16_add import systolic_pkg::*; (
    input  bf16_u a_i,
    input  bf16_u b_i,
    output bf16_u sum_o
);

    bf16_u            big;        // Larger magnitude operand
    bf16_u            small_op;
    logic [EXP_W-1:0] exp_diff;
    logic [MAN_W:0]   sig_big;
    logic [MAN_W:0]   sig_small;  // Aligned to the big exponent
    logic [MAN_W+1:0] sig_sum;    // One bit for the carry out
    logic             same_sign;
    logic             exc;

    // Swap on raw magnitude with the sign bit left out
    assign {big, small_op} = (a_i.raw[WORD_W-2:0] < b_i.raw[WORD_W-2:0]) ?
                             {b_i, a_i} : {a_i, b_i};

    assign exp_diff = big.f.exp - small_op.f.exp;

    // Hidden one only for a nonzero exponent so zero partial sums stay zero
    assign sig_big   = {|big.f.exp, big.f.frac};
    assign sig_small = {|small_op.f.exp, small_op.f.frac} >> exp_diff;  // Truncating alignment

    assign same_sign = (big.f.sign == small_op.f.sign);
    assign sig_sum   = same_sign ? ({1'b0, sig_big} + {1'b0, sig_small}) : '0;

    assign exc = (&big.f.exp) | (&small_op.f.exp);  // Inf or NaN on either side

    always_comb begin
        sum_o.f.sign = big.f.sign;
        if (sig_sum[MAN_W+1]) begin
            sum_o.f.exp  = big.f.exp + EXP_W'(1);  // Carry renormalises one place
            sum_o.f.frac = sig_sum[MAN_W:1];
        end else begin
            sum_o.f.exp  = big.f.exp;
            sum_o.f.frac = sig_sum[MAN_W-1:0];
        end
        if (exc) begin
            sum_o.raw = '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/bf16_mul.sv
`timescale 1ns/100ps
`default_nettype none

module bf16_mul import systolic_pkg::*; (
    input  bf16_u a_i,
    input  bf16_u b_i,
    output bf16_u prod_o
);

    logic [2*MAN_W+1:0] sig_prod;      // Full product of the two 8-bit significands
    logic               carry;         // Product landed in [2,4)
    logic [MAN_W-1:0]   frac;
    logic [EXP_W+1:0]   exp_sum;       // Two extra bits so the range check cannot wrap
    logic [EXP_W+1:0]   exp_res;
    logic               zero_in;
    logic               out_of_range;

    // Hidden one restored on both sides
    assign sig_prod = {1'b1, a_i.f.frac} * {1'b1, b_i.f.frac};
    assign carry    = sig_prod[2*MAN_W+1];

    // Fraction taken just below the leading one, low bits dropped
    assign frac = carry ? sig_prod[2*MAN_W -: MAN_W] : sig_prod[2*MAN_W-1 -: MAN_W];

    assign exp_sum = {2'b00, a_i.f.exp} + {2'b00, b_i.f.exp} + {{(EXP_W+1){1'b0}}, carry};
    assign exp_res = exp_sum - (EXP_W+2)'(EXP_BIAS);  // Remove the doubled bias

    assign zero_in = (a_i.f.exp == '0) || (b_i.f.exp == '0);

    // Biased result exponent has to stay within 1..EXP_MAX
    assign out_of_range = (exp_sum <= (EXP_W+2)'(EXP_BIAS)) ||
                          (exp_sum > (EXP_W+2)'(EXP_BIAS + EXP_MAX));

    always_comb begin
        prod_o.f.sign = a_i.f.sign ^ b_i.f.sign;
        prod_o.f.exp  = exp_res[EXP_W-1:0];
        prod_o.f.frac = frac;
        if (zero_in) begin
            prod_o.raw = '0;          // Any zero exponent input gives a clean zero
        end else if (out_of_range) begin
            prod_o.f.exp  = '1;       // Saturate to infinity, sign kept
            prod_o.f.frac = '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/systolic_pkg.sv
`default_nettype none

package systolic_pkg;

    localparam int WORD_W   = 16;              // bfloat16 word
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 7;               // Stored fraction, hidden one not counted
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = (1 << EXP_W) - 2; // Largest normal biased exponent
    localparam int BYTE_W   = 8;

    localparam int ARR_DIM       = 2;
    localparam int N_WORDS       = ARR_DIM * ARR_DIM;
    localparam int SKEW_LEN      = 2 * ARR_DIM - 1;  // Shift and deskew row length
    localparam int COMPUTE_STEPS = 6;
    localparam int STEP_W        = $clog2(COMPUTE_STEPS);

    localparam int WIDX_W      = $clog2(N_WORDS);        // Word index within one matrix
    localparam int OP_BYTES    = 4 * N_WORDS;            // A and B, two bytes per word
    localparam int OP_CNT_W    = WIDX_W + 2;
    localparam int REPLY_BYTES = 2 * N_WORDS + 2;        // Start, results, end
    localparam int REPLY_CNT_W = $clog2(REPLY_BYTES + 1);

    localparam logic [BYTE_W-1:0] FRAME_START = 8'hFE;
    localparam logic [BYTE_W-1:0] FRAME_END   = 8'hFF;

    // Frame receiver states
    localparam logic [1:0] RX_IDLE = 2'd0;
    localparam logic [1:0] RX_DATA = 2'd1;
    localparam logic [1:0] RX_TAIL = 2'd2;  // Waiting for the closing byte

    // Controller states
    localparam logic [1:0] CT_IDLE    = 2'd0;
    localparam logic [1:0] CT_LOAD    = 2'd1;
    localparam logic [1:0] CT_COMPUTE = 2'd2;
    localparam logic [1:0] CT_SEND    = 2'd3;

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [MAN_W-1:0] frac;
    } bf16_fields_t;

    // Same word seen raw for magnitude compares, or split into fields
    typedef union packed {
        logic [WORD_W-1:0] raw;
        bf16_fields_t      f;
    } bf16_u;

    typedef struct packed {
        bf16_u [N_WORDS-1:0] a;  // Column-major A
        bf16_u [N_WORDS-1:0] b;  // Column-major B
    } operands_t;

    typedef bf16_u [N_WORDS-1:0] results_t;  // Column-major C

    typedef struct packed {
        logic load;     // Latch weights and activations
        logic compute;  // Step enable
    } array_ctrl_t;

endpackage

`default_nettype wire
